// ==== compile.f ====
+incdir+hw
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_datapath.sv
hw/rv_status.sv
hw/rv_core.sv
test/rv_clock_gen.sv
test/rv_assertions.sv
test/rv_tb.sv

// ==== hw/rv_core.sv ====
// rv core top: single-cycle rv64 core joining decoder, register file, datapath and status
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module rv_core (
  input  logic                    clk,
  input  logic                    rst_n,
  input  rv_pkg::inst_t           imem_data,
  output rv_pkg::xlen_t           imem_addr,
  output logic                    dmem_wen,
  output rv_pkg::xlen_t           dmem_addr,
  output rv_pkg::xlen_t           dmem_wdata,
  output rv_pkg::wmask_t          dmem_wmask,
  output logic                    retire,
  output logic                    halted,
  output logic                    illegal,
  output logic [`RV_RETIRE_W-1:0] retired_count
);

  // decoder outputs
  rv_pkg::reg_idx_t    rd;
  rv_pkg::reg_idx_t    rs1;
  rv_pkg::reg_idx_t    rs2;
  rv_pkg::xlen_t       imm;
  logic                need_imm;
  logic                is_lui;
  logic                is_auipc;
  logic                is_jal;
  logic                is_store;
  rv_pkg::store_size_e store_size;
  logic                reg_wen;
  logic                is_ebreak;
  logic                is_illegal;

  // register file and writeback
  rv_pkg::xlen_t rdata_1;
  rv_pkg::xlen_t rdata_2;
  rv_pkg::xlen_t reg_wdata;
  logic          regfile_wen;

  // commit enable from status
  logic run;

  rv_decoder u_decoder (
    .inst       (imem_data),
    .rd         (rd),
    .rs1        (rs1),
    .rs2        (rs2),
    .imm        (imm),
    .need_imm   (need_imm),
    .is_lui     (is_lui),
    .is_auipc   (is_auipc),
    .is_jal     (is_jal),
    .is_store   (is_store),
    .store_size (store_size),
    .reg_wen    (reg_wen),
    .is_ebreak  (is_ebreak),
    .is_illegal (is_illegal)
  );

  rv_regfile u_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .wdata   (reg_wdata),
    .wen     (regfile_wen),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2)
  );

  // fetch address is the pc itself
  rv_datapath u_datapath (
    .clk         (clk),
    .rst_n       (rst_n),
    .run         (run),
    .rdata_1     (rdata_1),
    .rdata_2     (rdata_2),
    .imm         (imm),
    .need_imm    (need_imm),
    .is_lui      (is_lui),
    .is_auipc    (is_auipc),
    .is_jal      (is_jal),
    .is_store    (is_store),
    .store_size  (store_size),
    .reg_wen     (reg_wen),
    .pc          (imem_addr),
    .reg_wdata   (reg_wdata),
    .regfile_wen (regfile_wen),
    .dmem_wen    (dmem_wen),
    .dmem_addr   (dmem_addr),
    .dmem_wdata  (dmem_wdata),
    .dmem_wmask  (dmem_wmask)
  );

  rv_status u_status (
    .clk           (clk),
    .rst_n         (rst_n),
    .is_ebreak     (is_ebreak),
    .is_illegal    (is_illegal),
    .run           (run),
    .retire        (retire),
    .halted        (halted),
    .illegal       (illegal),
    .retired_count (retired_count)
  );

endmodule

`default_nettype wire

// ==== hw/rv_datapath.sv ====
// rv datapath: operand muxes, shared adder, writeback, store lanes and pc register
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module rv_datapath (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                run,
  input  rv_pkg::xlen_t       rdata_1,
  input  rv_pkg::xlen_t       rdata_2,
  input  rv_pkg::xlen_t       imm,
  input  logic                need_imm,
  input  logic                is_lui,
  input  logic                is_auipc,
  input  logic                is_jal,
  input  logic                is_store,
  input  rv_pkg::store_size_e store_size,
  input  logic                reg_wen,
  output rv_pkg::xlen_t       pc,
  output rv_pkg::xlen_t       reg_wdata,
  output logic                regfile_wen,
  output logic                dmem_wen,
  output rv_pkg::xlen_t       dmem_addr,
  output rv_pkg::xlen_t       dmem_wdata,
  output rv_pkg::wmask_t      dmem_wmask
);

  rv_pkg::xlen_t  operand_1;
  rv_pkg::xlen_t  operand_2;
  rv_pkg::xlen_t  sum;
  rv_pkg::xlen_t  pc_plus_4;
  rv_pkg::xlen_t  next_pc;
  logic [2:0]     byte_off;
  rv_pkg::wmask_t size_mask;

  // operand 1: pc for auipc, zero for lui, rs1 otherwise
  assign operand_1 = is_auipc ? pc : (is_lui ? '0 : rdata_1);
  // operand 2: immediate or rs2
  assign operand_2 = need_imm ? imm : rdata_2;

  // single adder serves alu, lui/auipc and store address
  assign sum       = operand_1 + operand_2;
  assign pc_plus_4 = pc + `RV_XLEN'd4;

  // jal links the return address
  assign reg_wdata   = is_jal ? pc_plus_4 : sum;
  assign regfile_wen = reg_wen & run;

  // byte lane within the double word
  assign byte_off = sum[2:0];

  // low 2^size bits set before shifting into place
  always_comb begin
    case (store_size)
      rv_pkg::SIZE_BYTE: size_mask = 8'h01;
      rv_pkg::SIZE_HALF: size_mask = 8'h03;
      rv_pkg::SIZE_WORD: size_mask = 8'h0f;
      default:           size_mask = 8'hff;
    endcase
  end

  // shifted mask drops lanes past bit 7, no wrap
  assign dmem_wen   = is_store & run;
  assign dmem_addr  = sum;
  assign dmem_wmask = size_mask << byte_off;
  assign dmem_wdata = rdata_2 << {byte_off, 3'b000};

  assign next_pc = is_jal ? (pc + imm) : pc_plus_4;

  // pc only moves on a committed instruction
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= `RV_PC_RESET;
    end else if (run) begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

// ==== hw/rv_decoder.sv ====
// rv decoder: splits an instruction into register indices, immediate and control strobes
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module rv_decoder (
  input  rv_pkg::inst_t       inst,
  output rv_pkg::reg_idx_t    rd,
  output rv_pkg::reg_idx_t    rs1,
  output rv_pkg::reg_idx_t    rs2,
  output rv_pkg::xlen_t       imm,
  output logic                need_imm,
  output logic                is_lui,
  output logic                is_auipc,
  output logic                is_jal,
  output logic                is_store,
  output rv_pkg::store_size_e store_size,
  output logic                reg_wen,
  output logic                is_ebreak,
  output logic                is_illegal
);

  // instruction fields
  rv_pkg::rv_opcode_e opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;

  // sign-extended immediates, one per format
  rv_pkg::xlen_t imm_i;
  rv_pkg::xlen_t imm_s;
  rv_pkg::xlen_t imm_u;
  rv_pkg::xlen_t imm_j;

  assign opcode = rv_pkg::rv_opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // I type: inst[31:20]
  assign imm_i = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
  // S type: split around rd field
  assign imm_s = {{(`RV_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
  // U type: upper 20 bits, low 12 zero
  assign imm_u = {{(`RV_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  // J type: scrambled offset, bit 0 always zero
  assign imm_j = {{(`RV_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                  inst[30:21], 1'b0};

  always_comb begin
    // register fields go out raw, strobes decide what is used
    rd         = inst[11:7];
    rs1        = inst[19:15];
    rs2        = inst[24:20];
    store_size = rv_pkg::store_size_e'(funct3[1:0]);

    // everything off unless an opcode below claims it
    imm        = '0;
    need_imm   = 1'b0;
    is_lui     = 1'b0;
    is_auipc   = 1'b0;
    is_jal     = 1'b0;
    is_store   = 1'b0;
    reg_wen    = 1'b0;
    is_ebreak  = 1'b0;
    is_illegal = 1'b0;

    case (opcode)
      rv_pkg::OP_IMM: begin
        // addi only
        if (funct3 == 3'b000) begin
          imm      = imm_i;
          need_imm = 1'b1;
          reg_wen  = 1'b1;
        end else begin
          is_illegal = 1'b1;
        end
      end
      rv_pkg::OP: begin
        // add only, sub and the rest rejected
        if (funct3 == 3'b000 && funct7 == 7'b0) begin
          reg_wen = 1'b1;
        end else begin
          is_illegal = 1'b1;
        end
      end
      rv_pkg::LUI: begin
        imm      = imm_u;
        need_imm = 1'b1;
        is_lui   = 1'b1;
        reg_wen  = 1'b1;
      end
      rv_pkg::AUIPC: begin
        imm      = imm_u;
        need_imm = 1'b1;
        is_auipc = 1'b1;
        reg_wen  = 1'b1;
      end
      rv_pkg::JAL: begin
        // link value comes from the datapath, not the adder
        imm     = imm_j;
        is_jal  = 1'b1;
        reg_wen = 1'b1;
      end
      rv_pkg::STORE: begin
        // sb, sh, sw, sd; funct3[2] set has no store
        if (funct3[2] == 1'b0) begin
          imm      = imm_s;
          need_imm = 1'b1;
          is_store = 1'b1;
        end else begin
          is_illegal = 1'b1;
        end
      end
      rv_pkg::SYSTEM: begin
        // exact match, ecall and csr ops are not implemented
        if (inst == rv_pkg::EBREAK_INST) begin
          is_ebreak = 1'b1;
        end else begin
          is_illegal = 1'b1;
        end
      end
      default: begin
        is_illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/rv_params.svh ====
// rv core parameters: datapath widths, reset pc and register file depth
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// integer register and data width
`define RV_XLEN 64

// fetched instruction width
`define RV_INST_W 32

// register index, five bits for x0..x31
`define RV_REG_IDX_W 5

// number of architectural integer registers
`define RV_REG_NUM 32

// first fetch address after reset
`define RV_PC_RESET 64'h8000_0000

// retired-instruction counter width
`define RV_RETIRE_W 32

`endif

// ==== hw/rv_pkg.sv ====
// rv core package: shared data types, opcode and store size encodings
`default_nettype none

`include "rv_params.svh"

package rv_pkg;

  // data word, instruction, register index
  typedef logic [`RV_XLEN-1:0] xlen_t;
  typedef logic [`RV_INST_W-1:0] inst_t;
  typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;

  // one bit per byte lane of the data word
  typedef logic [`RV_XLEN/8-1:0] wmask_t;

  // major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    STORE  = 7'b0100011,
    SYSTEM = 7'b1110011
  } rv_opcode_e;

  // store size as encoded in funct3[1:0]
  typedef enum logic [1:0] {
    SIZE_BYTE   = 2'd0,
    SIZE_HALF   = 2'd1,
    SIZE_WORD   = 2'd2,
    SIZE_DOUBLE = 2'd3
  } store_size_e;

  // the only SYSTEM encoding the core accepts
  localparam inst_t EBREAK_INST = 32'h0010_0073;

endpackage

`default_nettype wire

// ==== hw/rv_regfile.sv ====
// rv register file: 32 integer registers, two async read ports, one write port
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module rv_regfile (
  input  logic             clk,
  input  logic             rst_n,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::xlen_t    wdata,
  input  logic             wen,
  output rv_pkg::xlen_t    rdata_1,
  output rv_pkg::xlen_t    rdata_2
);

  rv_pkg::xlen_t regs [`RV_REG_NUM];

  // write on the edge; x0 never written
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_REG_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // async reads, x0 forced to zero
  assign rdata_1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata_2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== hw/rv_status.sv ====
// rv status: start, halt and illegal state, commit enable and retired count
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module rv_status (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    is_ebreak,
  input  logic                    is_illegal,
  output logic                    run,
  output logic                    retire,
  output logic                    halted,
  output logic                    illegal,
  output logic [`RV_RETIRE_W-1:0] retired_count
);

  // set one cycle after reset release, holds until next reset
  logic started;

  // commit allowed only when live and the encoding is known
  assign run    = started & ~halted & ~is_illegal;
  assign retire = run;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      started       <= 1'b0;
      halted        <= 1'b0;
      illegal       <= 1'b0;
      retired_count <= '0;
    end else begin
      started <= 1'b1;
      // ebreak halts after retiring
      if (run && is_ebreak) begin
        halted <= 1'b1;
      end
      // bad encoding halts without retiring
      if (started && !halted && is_illegal) begin
        halted  <= 1'b1;
        illegal <= 1'b1;
      end
      if (retire) begin
        retired_count <= retired_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
rm -f sim.log obj_dir/rv_sim
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module rv_tb -o rv_sim \
  && { ./obj_dir/rv_sim > sim.log 2>&1 || true; }
grep -qxF "Simulation finished: PASS" sim.log \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed, see sim.log"; exit 1; }

// ==== test/rv_assertions.sv ====
// rv core checker for store, retire and halt rules on every clock
`timescale 1ns/1ns
`default_nettype none

module rv_assertions (
  input logic       clk,
  input logic       rst_n,
  input logic       retire,
  input logic       halted,
  input logic       dmem_wen,
  input logic [7:0] dmem_wmask
);

  // failed property count, read by the testbench
  int fail_count = 0;

  // a store only leaves with a committed instruction
  store_needs_retire: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_wen |-> retire)
    else begin
      fail_count++;
      $error("store presented without retire");
    end

  // halt is left only through reset
  halt_is_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    halted |=> halted)
    else begin
      fail_count++;
      $error("halted fell while out of reset");
    end

  no_retire_when_halted: assert property (@(posedge clk) disable iff (!rst_n)
    halted |-> !retire)
    else begin
      fail_count++;
      $error("retire high while halted");
    end

  // at least one byte lane per store
  store_mask_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_wen |-> (dmem_wmask != 8'h00))
    else begin
      fail_count++;
      $error("store with empty byte mask");
    end

endmodule

bind rv_core rv_assertions u_assertions (
  .clk        (clk),
  .rst_n      (rst_n),
  .retire     (retire),
  .halted     (halted),
  .dmem_wen   (dmem_wen),
  .dmem_wmask (dmem_wmask)
);

`default_nettype wire

// ==== test/rv_clock_gen.sv ====
// rv testbench clock and reset: 20 ns clock, reset held low for two rising edges
`timescale 1ns/1ns
`default_nettype none

module rv_clock_gen (
  input  logic restart,
  output logic clk,
  output logic rst_n
);

  // rising edges of reset still to go
  int   left;
  logic req;

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    left  = 2;
  end

  always #10 clk = ~clk;

  // restart sampled on the edge, reset changes shortly after it
  always @(posedge clk) begin
    req = restart;
    #2;
    if (req) begin
      left = 2;
    end else if (left != 0) begin
      left = left - 1;
    end
    rst_n = (left == 0);
  end

endmodule

`default_nettype wire

// ==== test/rv_tb.sv ====
// rv core testbench with random programs, instruction memory and an ISA reference model
`timescale 1ns/1ns
`default_nettype none

`include "rv_params.svh"

module rv_tb;

  localparam int PROG_LEN = 64;
  localparam logic [31:0] EBREAK = 32'h0010_0073;

  logic clk;
  logic rst_n;
  logic restart;
  rv_pkg::inst_t  imem_data;
  rv_pkg::xlen_t  imem_addr;
  rv_pkg::xlen_t  dmem_addr;
  rv_pkg::xlen_t  dmem_wdata;
  rv_pkg::wmask_t dmem_wmask;
  logic dmem_wen;
  logic retire;
  logic halted;
  logic illegal;
  logic [`RV_RETIRE_W-1:0] retired_count;

  // program memory and model state
  rv_pkg::inst_t prog [PROG_LEN];
  rv_pkg::xlen_t m_regs [32];
  rv_pkg::xlen_t m_pc;
  int m_count;
  logic [31:0] rng;

  rv_clock_gen u_clock_gen (.restart(restart), .clk(clk), .rst_n(rst_n));

  rv_core dut (
    .clk (clk), .rst_n (rst_n), .imem_data (imem_data), .imem_addr (imem_addr),
    .dmem_wen (dmem_wen), .dmem_addr (dmem_addr), .dmem_wdata (dmem_wdata),
    .dmem_wmask (dmem_wmask), .retire (retire), .halted (halted),
    .illegal (illegal), .retired_count (retired_count)
  );

  // word fetch where anything outside the program reads ebreak
  function automatic rv_pkg::inst_t fetch(input rv_pkg::xlen_t addr);
    rv_pkg::xlen_t idx;
    idx = (addr - `RV_PC_RESET) >> 2;
    if (addr >= `RV_PC_RESET && idx < PROG_LEN) begin
      return prog[idx];
    end
    return EBREAK;
  endfunction

  always_comb imem_data = fetch(imem_addr);

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function logic [31:0] rnd();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic rv_pkg::inst_t enc_jal(input logic [4:0] rd, input int words);
    logic [20:0] off;
    off = 21'(words * 4);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic rv_pkg::inst_t enc_store(input logic [1:0] size, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [11:0] off);
    return {off[11:5], rs2, rs1, 1'b0, size, off[4:0], 7'b0100011};
  endfunction

  // one random instruction over x0..x7
  function automatic rv_pkg::inst_t rand_inst(input logic allow_jal);
    logic [31:0] r;
    logic [31:0] v;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    int kind;
    r    = rnd();
    v    = rnd();
    rd   = {2'b00, r[2:0]};
    rs1  = {2'b00, r[5:3]};
    rs2  = {2'b00, r[8:6]};
    kind = int'(r[15:12]) % (allow_jal ? 7 : 6);
    case (kind)
      0: return {v[11:0], rs1, 3'b000, rd, 7'b0010011};
      1: return {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
      2: return {v[31:12], rd, 7'b0110111};
      3: return {v[31:12], rd, 7'b0010111};
      4, 5: return enc_store(r[11:10], rs2, rs1, v[11:0]);
      default: return enc_jal(rd, int'(r[17:16]) % 3 + 1);
    endcase
  endfunction

  task automatic gen_program(input int n, input logic allow_jal, input int bad_at);
    for (int i = 0; i < PROG_LEN; i++) begin
      prog[i] = (i < n) ? rand_inst(allow_jal) : EBREAK;
    end
    if (allow_jal) begin
      // link into x5 and store it, then jal with rd x0 and store x0
      prog[0] = enc_jal(5'd5, 2);
      prog[2] = enc_store(2'd3, 5'd5, 5'd0, 12'h010);
      prog[3] = enc_jal(5'd0, 1);
      prog[4] = enc_store(2'd3, 5'd0, 5'd5, 12'h7f8);
    end
    // sub is outside the supported set
    if (bad_at >= 0) begin
      prog[bad_at] = 32'h4020_81b3;
    end
  endtask

  task automatic clear_model();
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    m_pc    = `RV_PC_RESET;
    m_count = 0;
  endtask

  // executes one instruction on the model and reports legality and store
  task automatic model_exec(input rv_pkg::inst_t inst, output logic legal, output logic brk,
                            output logic st, output rv_pkg::xlen_t addr,
                            output rv_pkg::xlen_t data, output logic [7:0] mask);
    rv_pkg::xlen_t a;
    rv_pkg::xlen_t b;
    rv_pkg::xlen_t wb;
    rv_pkg::xlen_t npc;
    rv_pkg::xlen_t imm_u;
    logic [15:0]   lanes;
    logic          wr;
    a     = m_regs[inst[19:15]];
    b     = m_regs[inst[24:20]];
    imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
    legal = 1'b1;
    brk   = 1'b0;
    st    = 1'b0;
    wr    = 1'b0;
    wb    = '0;
    addr  = '0;
    data  = '0;
    mask  = '0;
    npc   = m_pc + 64'd4;
    case (inst[6:0])
      7'b0010011: begin
        wr    = 1'b1;
        wb    = a + {{52{inst[31]}}, inst[31:20]};
        legal = (inst[14:12] == 3'b000);
      end
      7'b0110011: begin
        wr    = 1'b1;
        wb    = a + b;
        legal = (inst[14:12] == 3'b000) && (inst[31:25] == 7'b0);
      end
      7'b0110111: begin
        wr = 1'b1;
        wb = imm_u;
      end
      7'b0010111: begin
        wr = 1'b1;
        wb = m_pc + imm_u;
      end
      7'b1101111: begin
        wr  = 1'b1;
        wb  = m_pc + 64'd4;
        npc = m_pc + {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      7'b0100011: begin
        // 1, 2, 4 or 8 bytes placed at the address offset
        st    = !inst[14];
        legal = !inst[14];
        addr  = a + {{52{inst[31]}}, inst[31:25], inst[11:7]};
        lanes = ((16'd1 << (16'd1 << inst[13:12])) - 16'd1) << addr[2:0];
        mask  = lanes[7:0];
        data  = b << (8 * addr[2:0]);
      end
      default: begin
        brk   = (inst == EBREAK);
        legal = brk;
      end
    endcase
    if (legal) begin
      if (wr && inst[11:7] != 5'd0) begin
        m_regs[inst[11:7]] = wb;
      end
      m_pc    = npc;
      m_count = m_count + 1;
    end
  endtask

  task automatic stop_fail();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
      stop_fail();
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout: %s", what);
    stop_fail();
  endtask

  // failures counted by the bound checker
  always @(negedge clk) begin
    if (dut.u_assertions.fail_count != 0) begin
      $display("A concurrent assertion on the core failed");
      stop_fail();
    end
  end

  // one-cycle restart request and then wait out the reset
  task automatic pulse_reset();
    int guard;
    guard = 0;
    @(posedge clk);
    #2 restart = 1'b1;
    @(posedge clk);
    #2 restart = 1'b0;
    @(negedge clk);
    while (!rst_n || guard == 0) begin
      guard++;
      if (guard > 10) begin
        timeout_fail("reset did not release");
      end
      @(negedge clk);
    end
  endtask

  task automatic run_program(input logic expect_illegal);
    int guard;
    logic legal;
    logic brk;
    logic st;
    logic done;
    rv_pkg::xlen_t addr;
    rv_pkg::xlen_t data;
    logic [7:0] mask;
    guard = 0;
    done  = 1'b0;
    // quiet until the first commit
    @(negedge clk);
    while (!retire) begin
      check("dmem_wen", dmem_wen, 0);
      check("halted", halted, 0);
      check("illegal", illegal, 0);
      guard++;
      if (guard > 10) begin
        timeout_fail("no retire after reset");
      end
      @(negedge clk);
    end
    check("imem_addr", imem_addr, `RV_PC_RESET);
    guard = 0;
    while (!done) begin
      check("imem_addr", imem_addr, m_pc);
      check("halted", halted, 0);
      model_exec(fetch(m_pc), legal, brk, st, addr, data, mask);
      check("retire", retire, legal);
      check("dmem_wen", dmem_wen, st);
      if (st) begin
        check("dmem_addr", dmem_addr, addr);
        check("dmem_wmask", dmem_wmask, mask);
        check("dmem_wdata", dmem_wdata, data);
      end
      done = !legal || brk;
      guard++;
      if (guard > 4 * PROG_LEN) begin
        timeout_fail("program never reached a halt");
      end
      @(negedge clk);
    end
    check("halted", halted, 1);
    check("illegal", illegal, expect_illegal);
    check("retired_count", retired_count, m_count);
    // stays stopped
    for (int i = 0; i < 5; i++) begin
      check("retire", retire, 0);
      check("halted", halted, 1);
      @(negedge clk);
    end
  endtask

  initial begin
    restart = 1'b0;
    rng     = 32'hdd11_23d7;
    // jal-heavy random program ending in ebreak
    clear_model();
    gen_program(48, 1'b1, -1);
    run_program(1'b0);
    // straight-line program stopped by a bad encoding
    pulse_reset();
    clear_model();
    gen_program(24, 1'b0, 13);
    run_program(1'b1);
    check("retired_count", retired_count, 13);
    if (dut.u_assertions.fail_count == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      stop_fail();
    end
  end

endmodule

`default_nettype wire
